//--- Bender.yml
package:
  name: plic

sources:
  - include_dirs:
      - src
    files:
      - src/plic_pkg.sv
      - src/plic_cfg_if.sv
      - src/plic_regs.sv
      - src/plic_gateway.sv
      - src/plic_target.sv
      - src/plic_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/plic_asserts.sv
      - dv/plic_tb.sv

//--- compile.f
+incdir+src
src/plic_pkg.sv
src/plic_cfg_if.sv
src/plic_regs.sv
src/plic_gateway.sv
src/plic_target.sv
src/plic_top.sv
dv/plic_asserts.sv
dv/plic_tb.sv

//--- dv/plic_asserts.sv
// concurrent checks on bus response timing and gateway bits,
// bound into the controller top level

`include "plic_consts.svh"

module plic_asserts (
    input logic                  i_clk,
    input logic                  i_nrst,
    input logic                  i_req_valid,
    input logic                  i_req_write,
    input logic                  i_rsp_valid,
    input logic [`PLIC_NCTX-1:0] i_irq,
    input logic [`PLIC_NSRC-1:0] i_pending,
    input logic [`PLIC_NSRC-1:0] i_in_service
);

    timeunit 1ns;
    timeprecision 100ps;

    int n_fail = 0;

    a_rsp_after_read: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_req_valid && !i_req_write) |=> i_rsp_valid)
        else begin
            n_fail++;
            $error("read request got no response in the next cycle");
        end

    a_no_stray_rsp: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_rsp_valid |-> $past(i_req_valid && !i_req_write))
        else begin
            n_fail++;
            $error("response without a read one cycle before");
        end

    a_irq_low_in_reset: assert property (@(posedge i_clk)
        !i_nrst |-> (i_irq == '0))
        else begin
            n_fail++;
            $error("irq raised during reset");
        end

    // source 0 does not exist
    a_src0_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_pending[0] && !i_in_service[0])
        else begin
            n_fail++;
            $error("source 0 pending or in service");
        end

    a_pend_xor_service: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_pending & i_in_service) == '0)
        else begin
            n_fail++;
            $error("source both pending and in service");
        end

endmodule

//--- dv/plic_tb.sv
// random testbench for the interrupt controller with a reference model
// drives bus requests and source levels from a fixed seed, checks reads and irq lines

`include "plic_consts.svh"

module plic_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_OPS      = 400;
    localparam int MAX_CYCLES = 4000;   // under 7 cycles per op plus reset and latency test

    logic                    i_clk;
    logic                    i_nrst;
    logic [`PLIC_NSRC-1:0]   i_irq_src;
    logic                    i_req_valid;
    logic                    i_req_write;
    logic [`PLIC_ADDR_W-1:0] i_req_addr;
    logic [31:0]             i_req_wdata;
    logic                    o_rsp_valid;
    logic [31:0]             o_rsp_rdata;
    logic [`PLIC_NCTX-1:0]   o_irq;

    integer seed   = 32'he28d0efa;
    int     errors = 0;
    int     cycles = 0;

    // reference model
    logic [`PLIC_PRIO_W-1:0] m_prio [`PLIC_NSRC];
    logic [`PLIC_NSRC-1:0]   m_en [`PLIC_NCTX];
    logic [`PLIC_PRIO_W-1:0] m_thr [`PLIC_NCTX];
    logic [`PLIC_NSRC-1:0]   m_pend;
    logic [`PLIC_NSRC-1:0]   m_insvc;
    logic [`PLIC_ID_W-1:0]   claimed [$];     // ids handed out and maybe not completed yet

    plic_top u_dut (.*);

    bind plic_top plic_asserts u_asserts (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_write  (i_req_write),
        .i_rsp_valid  (o_rsp_valid),
        .i_irq        (o_irq),
        .i_pending    (u_cfg.pending),
        .i_in_service (u_gateway.r_in_service)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic int rnd(int n);
        return {$random(seed)} % n;
    endfunction

    task automatic check(string what, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("** Error @ %0d ns: %s got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // walk priority levels from the top so the first enabled pending id at a level wins
    function automatic logic [`PLIC_ID_W-1:0] model_best(int c);
        for (int p = (1 << `PLIC_PRIO_W) - 1; p > m_thr[c]; p--) begin
            for (int i = 1; i < `PLIC_NSRC; i++) begin
                if (m_pend[i] && m_en[c][i] && m_prio[i] == p) return i[`PLIC_ID_W-1:0];
            end
        end
        return '0;
    endfunction

    function automatic logic [31:0] model_read(logic [`PLIC_ADDR_W-1:0] a);
        logic [31:0] d;
        d = '0;                                     // unmapped words read 0
        for (int s = 1; s < `PLIC_NSRC; s++) begin
            if (a == `PLIC_PRIO_BASE + 4 * s) d = m_prio[s];
        end
        if (a == `PLIC_PEND_ADDR) d = m_pend;
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            if (a == `PLIC_EN_BASE + c * `PLIC_CTX_STRIDE) d = m_en[c];
            if (a == `PLIC_THR_BASE + c * `PLIC_CTX_STRIDE) d = m_thr[c];
            if (a == `PLIC_CLAIM_BASE + c * `PLIC_CTX_STRIDE) d = model_best(c);
        end
        return d;
    endfunction

    task automatic model_write(logic [`PLIC_ADDR_W-1:0] a, logic [31:0] d);
        for (int s = 1; s < `PLIC_NSRC; s++) begin
            if (a == `PLIC_PRIO_BASE + 4 * s) m_prio[s] = d[`PLIC_PRIO_W-1:0];
        end
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            if (a == `PLIC_EN_BASE + c * `PLIC_CTX_STRIDE) m_en[c] = d[`PLIC_NSRC-1:0] & ~16'h1;
            if (a == `PLIC_THR_BASE + c * `PLIC_CTX_STRIDE) m_thr[c] = d[`PLIC_PRIO_W-1:0];
            if (a == `PLIC_CLAIM_BASE + c * `PLIC_CTX_STRIDE) m_insvc[d[`PLIC_ID_W-1:0]] = 1'b0;
        end
        m_insvc[0] = 1'b0;                          // completing id 0 does nothing
    endtask

    // wait out the pipeline, latch levels into the model, compare irq lines
    task automatic settle();
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        for (int i = 1; i < `PLIC_NSRC; i++) begin
            if (i_irq_src[i] && m_prio[i] != 0 && !m_insvc[i]) m_pend[i] = 1'b1;
        end
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            check($sformatf("irq of context %0d", c), o_irq[c], model_best(c) != 0);
        end
    endtask

    task automatic bus_write(logic [`PLIC_ADDR_W-1:0] a, logic [31:0] d);
        @(posedge i_clk);
        i_req_valid <= 1'b1;
        i_req_write <= 1'b1;
        i_req_addr  <= a;
        i_req_wdata <= d;
        @(posedge i_clk);
        i_req_valid <= 1'b0;
        model_write(a, d);
        settle();
    endtask

    task automatic bus_read(logic [`PLIC_ADDR_W-1:0] a, string what, bit claim);
        logic [31:0] want;
        want = model_read(a);
        @(posedge i_clk);
        i_req_valid <= 1'b1;
        i_req_write <= 1'b0;
        i_req_addr  <= a;
        @(posedge i_clk);
        i_req_valid <= 1'b0;
        @(negedge i_clk);
        check("response one cycle after read", o_rsp_valid, 1'b1);
        check($sformatf("%s at %0h", what, a), o_rsp_rdata, want);
        if (claim && want != 0) begin               // a zero claim leaves everything alone
            m_pend[want[`PLIC_ID_W-1:0]]  = 1'b0;
            m_insvc[want[`PLIC_ID_W-1:0]] = 1'b1;
            claimed.push_back(want[`PLIC_ID_W-1:0]);
        end
        settle();
    endtask

    function automatic logic [`PLIC_ADDR_W-1:0] pick_addr();
        case (rnd(5))
            0: return `PLIC_PRIO_BASE + 4 * rnd(`PLIC_NSRC);
            1: return `PLIC_EN_BASE + `PLIC_CTX_STRIDE * rnd(`PLIC_NCTX);
            2: return `PLIC_THR_BASE + `PLIC_CTX_STRIDE * rnd(`PLIC_NCTX);
            3: return `PLIC_PEND_ADDR;
            default: return 12'h400 + 4 * rnd(256);  // nothing mapped from 0x400 up
        endcase
    endfunction

    initial begin
        logic [`PLIC_ID_W-1:0] id;
        int                    k;
        int                    n_assert;
        i_nrst      = 1'b1;
        i_irq_src   = '0;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_addr  = '0;
        i_req_wdata = '0;
        m_prio  = '{default: '0};
        m_en    = '{default: '0};
        m_thr   = '{default: '0};
        m_pend  = '0;
        m_insvc = '0;
        #1;
        i_nrst = 1'b0;                              // falling edge clears the flops before the first clock
        repeat (5) @(posedge i_clk);
        i_nrst <= 1'b1;

        // irq rises two cycles after one enabled source requests on an idle controller
        bus_write(`PLIC_PRIO_BASE + 4 * 5, 32'd3);
        bus_write(`PLIC_EN_BASE, 32'h20);
        @(posedge i_clk);
        i_irq_src[5] <= 1'b1;
        @(negedge i_clk);
        check("irq before the request is sampled", o_irq[0], 1'b0);
        @(negedge i_clk);
        check("irq one cycle after the request", o_irq[0], 1'b0);
        @(negedge i_clk);
        check("irq two cycles after the request", o_irq[0], 1'b1);
        settle();

        for (int n = 0; n < N_OPS; n++) begin
            case (rnd(8))
                0: bus_write(`PLIC_PRIO_BASE + 4 * rnd(`PLIC_NSRC), $random(seed));
                1: bus_write(`PLIC_EN_BASE + `PLIC_CTX_STRIDE * rnd(`PLIC_NCTX), $random(seed));
                2: bus_write(`PLIC_THR_BASE + `PLIC_CTX_STRIDE * rnd(`PLIC_NCTX), $random(seed));
                3: begin
                    @(posedge i_clk);
                    i_irq_src <= $random(seed);
                    settle();
                end
                4: bus_read(pick_addr(), "readback", 1'b0);
                5: bus_read(`PLIC_CLAIM_BASE + `PLIC_CTX_STRIDE * rnd(`PLIC_NCTX), "claim", 1'b1);
                6: begin
                    id = rnd(`PLIC_NSRC);
                    if (claimed.size() > 0 && rnd(4) != 0) begin
                        k  = rnd(claimed.size());
                        id = claimed[k];
                        claimed.delete(k);
                    end
                    bus_write(`PLIC_CLAIM_BASE + `PLIC_CTX_STRIDE * rnd(`PLIC_NCTX), id);
                end
                default: bus_read(`PLIC_PEND_ADDR, "pending mask", 1'b0);
            endcase
        end

        n_assert = u_dut.u_asserts.n_fail;
        $display("done: %0d check errors, %0d assertion failures", errors, n_assert);
        if (errors == 0 && n_assert == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src/plic_cfg_if.sv
// configuration and claim/complete traffic between the register block
// and the interrupt logic (gateway and targets)

`include "plic_consts.svh"

interface plic_cfg_if import plic_pkg::*; ();

    // register block side
    plic_prio_t [`PLIC_NSRC-1:0] src_prio;
    logic [`PLIC_NSRC-1:0]       enable [`PLIC_NCTX];   // bit 0 always clear
    plic_prio_t                  threshold [`PLIC_NCTX];
    logic                        claim_stb;             // one cycle per claim read
    plic_id_t                    claim_id;
    logic                        complete_stb;          // one cycle per claim write
    plic_id_t                    complete_id;

    // interrupt logic side
    logic [`PLIC_NSRC-1:0]       pending;
    plic_id_t                    best_id [`PLIC_NCTX];  // registered winner per context

    modport regs (
        output src_prio, enable, threshold,
        output claim_stb, claim_id, complete_stb, complete_id,
        input  pending, best_id
    );

    modport core (
        input  src_prio, enable, threshold,
        input  claim_stb, claim_id, complete_stb, complete_id,
        output pending, best_id
    );

endinterface

//--- src/plic_consts.svh
// sizes and register map of the interrupt controller
// include wherever a count, a width or a bus address is needed

`ifndef PLIC_CONSTS_SVH
`define PLIC_CONSTS_SVH

`define PLIC_NSRC        16          // sources including the unused source 0
`define PLIC_NCTX        2           // interrupt targets
`define PLIC_CTX_W       1           // bits to index a context
`define PLIC_PRIO_W      3           // priority 0 means never
`define PLIC_ID_W        4
`define PLIC_ADDR_W      12          // byte address

`define PLIC_PRIO_BASE   12'h000     // one word per source
`define PLIC_PEND_ADDR   12'h080     // read only
`define PLIC_EN_BASE     12'h100
`define PLIC_THR_BASE    12'h200
`define PLIC_CLAIM_BASE  12'h204     // read claims, write completes
`define PLIC_CTX_STRIDE  12'h010     // per context step for enable, threshold, claim

`endif

//--- src/plic_gateway.sv
// interrupt gateway: latches level requests into pending bits and tracks
// which sources are in service between claim and complete

`include "plic_consts.svh"

module plic_gateway (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic [`PLIC_NSRC-1:0] i_irq_src,
    plic_cfg_if.core              cfg
);

    logic [`PLIC_NSRC-1:0] r_pending;
    logic [`PLIC_NSRC-1:0] r_in_service;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_pending    <= '0;
            r_in_service <= '0;
        end else begin
            // source 0 is never touched so both its bits stay clear
            for (int i = 1; i < `PLIC_NSRC; i++) begin
                if (i_irq_src[i] && (cfg.src_prio[i] != '0) && !r_in_service[i]) begin
                    r_pending[i] <= 1'b1;
                end
            end
            // a claim overrides a new request for the same source
            if (cfg.claim_stb && (cfg.claim_id != '0)) begin
                r_pending[cfg.claim_id]    <= 1'b0;
                r_in_service[cfg.claim_id] <= 1'b1;
            end
            if (cfg.complete_stb && (cfg.complete_id != '0)) begin
                r_in_service[cfg.complete_id] <= 1'b0;  // level re-latches a cycle later
            end
        end
    end

    assign cfg.pending = r_pending;

endmodule

//--- src/plic_pkg.sv
// shared types of the interrupt controller
// modules pull these in with a wildcard import in their header

`include "plic_consts.svh"

package plic_pkg;

    typedef logic [`PLIC_ID_W-1:0]   plic_id_t;    // source id, 0 is no interrupt
    typedef logic [`PLIC_PRIO_W-1:0] plic_prio_t;
    typedef logic [`PLIC_CTX_W-1:0]  plic_ctx_t;

    // direction of a bus request
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // register region hit by a bus address
    typedef enum logic [2:0] {
        REG_PRIO,
        REG_PEND,
        REG_EN,
        REG_THR,
        REG_CLAIM,
        REG_NONE
    } plic_region_e;

endpackage

//--- src/plic_regs.sv
// register block: decodes single-cycle bus requests, keeps priority, enable
// and threshold, answers reads one cycle later and issues claim/complete strobes

`include "plic_consts.svh"

module plic_regs import plic_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_req_valid,
    input  bus_op_e                 i_req_write,
    input  logic [`PLIC_ADDR_W-1:0] i_req_addr,
    input  logic [31:0]             i_req_wdata,
    output logic                    o_rsp_valid,
    output logic [31:0]             o_rsp_rdata,
    plic_cfg_if.regs                cfg
);

    plic_region_e          region;
    plic_id_t              sel_src;
    plic_ctx_t             sel_ctx;
    logic                  is_read;
    logic                  is_write;
    logic [31:0]           rd_data;

    plic_prio_t [`PLIC_NSRC-1:0] r_prio;
    logic [`PLIC_NSRC-1:0]       r_enable [`PLIC_NCTX];
    plic_prio_t                  r_thr [`PLIC_NCTX];
    logic                        r_rsp_valid;
    logic [31:0]                 r_rdata;

    assign is_read  = i_req_valid && (i_req_write == OP_READ);
    assign is_write = i_req_valid && (i_req_write == OP_WRITE);

    // address decode, anything not matched below stays REG_NONE
    always_comb begin
        region  = REG_NONE;
        sel_src = '0;
        sel_ctx = '0;
        for (int s = 1; s < `PLIC_NSRC; s++) begin      // source 0 has no priority word
            if (int'(i_req_addr) == `PLIC_PRIO_BASE + 4 * s) begin
                region  = REG_PRIO;
                sel_src = plic_id_t'(s);
            end
        end
        if (i_req_addr == `PLIC_PEND_ADDR) begin
            region = REG_PEND;
        end
        for (int c = 0; c < `PLIC_NCTX; c++) begin
            if (int'(i_req_addr) == `PLIC_EN_BASE + c * `PLIC_CTX_STRIDE) begin
                region  = REG_EN;
                sel_ctx = plic_ctx_t'(c);
            end
            if (int'(i_req_addr) == `PLIC_THR_BASE + c * `PLIC_CTX_STRIDE) begin
                region  = REG_THR;
                sel_ctx = plic_ctx_t'(c);
            end
            if (int'(i_req_addr) == `PLIC_CLAIM_BASE + c * `PLIC_CTX_STRIDE) begin
                region  = REG_CLAIM;
                sel_ctx = plic_ctx_t'(c);
            end
        end
    end

    // read mux, fields are zero extended
    always_comb begin
        rd_data = '0;
        case (region)
            REG_PRIO:  rd_data[`PLIC_PRIO_W-1:0] = r_prio[sel_src];
            REG_PEND:  rd_data[`PLIC_NSRC-1:0]   = cfg.pending;
            REG_EN:    rd_data[`PLIC_NSRC-1:0]   = r_enable[sel_ctx];
            REG_THR:   rd_data[`PLIC_PRIO_W-1:0] = r_thr[sel_ctx];
            REG_CLAIM: rd_data[`PLIC_ID_W-1:0]   = cfg.best_id[sel_ctx];
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_prio      <= '0;
            r_enable    <= '{default: '0};
            r_thr       <= '{default: '0};
            r_rsp_valid <= 1'b0;
        end else begin
            r_rsp_valid <= is_read;               // every read answers next cycle
            if (is_write) begin
                case (region)
                    REG_PRIO: r_prio[sel_src]    <= i_req_wdata[`PLIC_PRIO_W-1:0];
                    REG_EN:   r_enable[sel_ctx]  <= {i_req_wdata[`PLIC_NSRC-1:1], 1'b0};
                    REG_THR:  r_thr[sel_ctx]     <= i_req_wdata[`PLIC_PRIO_W-1:0];
                    default:  ;                   // pending is read only
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (is_read) begin
            r_rdata <= rd_data;
        end
    end

    assign o_rsp_valid = r_rsp_valid;
    assign o_rsp_rdata = r_rdata;

    assign cfg.src_prio  = r_prio;
    assign cfg.enable    = r_enable;
    assign cfg.threshold = r_thr;

    // a claim read hands out the winner seen at the request
    assign cfg.claim_stb    = is_read && (region == REG_CLAIM) && (cfg.best_id[sel_ctx] != '0);
    assign cfg.claim_id     = cfg.best_id[sel_ctx];
    assign cfg.complete_stb = is_write && (region == REG_CLAIM);
    assign cfg.complete_id  = i_req_wdata[`PLIC_ID_W-1:0];

endmodule

//--- src/plic_target.sv
// per-context selection of the highest priority pending source above threshold
// winner is registered, so o_irq follows pending and config by one cycle

`include "plic_consts.svh"

module plic_target import plic_pkg::*; (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic [`PLIC_NSRC-1:0]       i_pending,
    input  plic_prio_t [`PLIC_NSRC-1:0] i_src_prio,
    input  logic [`PLIC_NSRC-1:0]       i_enable,
    input  plic_prio_t                  i_threshold,
    output plic_id_t                    o_best_id,
    output logic                        o_irq
);

    plic_id_t   best_id;
    plic_prio_t best_prio;
    plic_id_t   r_best_id;

    // ascending scan with strict compare keeps the lowest id on a tie
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 1; i < `PLIC_NSRC; i++) begin
            if (i_pending[i] && i_enable[i]
                    && (i_src_prio[i] > i_threshold)
                    && (i_src_prio[i] > best_prio)) begin
                best_id   = plic_id_t'(i);
                best_prio = i_src_prio[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_best_id <= '0;
        end else begin
            r_best_id <= best_id;
        end
    end

    assign o_best_id = r_best_id;
    assign o_irq     = (r_best_id != '0);   // id 0 means nothing to take

endmodule

//--- src/plic_top.sv
// top level of the interrupt controller with a plain single-cycle register bus
// read data returns one cycle after the request, writes give no response

`include "plic_consts.svh"

module plic_top import plic_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic [`PLIC_NSRC-1:0]   i_irq_src,      // bit 0 is unused
    input  logic                    i_req_valid,
    input  logic                    i_req_write,    // 1 for write
    input  logic [`PLIC_ADDR_W-1:0] i_req_addr,
    input  logic [31:0]             i_req_wdata,
    output logic                    o_rsp_valid,
    output logic [31:0]             o_rsp_rdata,
    output logic [`PLIC_NCTX-1:0]   o_irq
);

    plic_cfg_if u_cfg ();

    plic_regs u_regs (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (i_req_valid),
        .i_req_write (bus_op_e'(i_req_write)),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_rdata (o_rsp_rdata),
        .cfg         (u_cfg.regs)
    );

    plic_gateway u_gateway (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_irq_src (i_irq_src),
        .cfg       (u_cfg.core)
    );

    // one selector per context, winners go back to the register block
    for (genvar g = 0; g < `PLIC_NCTX; g++) begin : g_target
        plic_target u_target (
            .i_clk       (i_clk),
            .i_nrst      (i_nrst),
            .i_pending   (u_cfg.pending),
            .i_src_prio  (u_cfg.src_prio),
            .i_enable    (u_cfg.enable[g]),
            .i_threshold (u_cfg.threshold[g]),
            .o_best_id   (u_cfg.best_id[g]),
            .o_irq       (o_irq[g])
        );
    end

endmodule
